/* source/vjc_params.svh */
////////////////////////////////////////////////////////////
// vertex job controller parameters
// line geometry, address width and job queue depth
////////////////////////////////////////////////////////////

`ifndef VJC_PARAMS_SVH
`define VJC_PARAMS_SVH

// vertex words held in one memory line
`define VJC_LINE_WORDS 8

// bits per vertex word
`define VJC_WORD_BITS 32

// byte address width of the read port
`define VJC_ADDR_BITS 32

// job queue entries, two lines' worth
`define VJC_JOB_DEPTH 16

`endif

/* source/mem_req_pkg.sv */
////////////////////////////////////////////////////////////
// memory traffic types
// read command address, returned line, array select and
// chunk word count
////////////////////////////////////////////////////////////

`default_nettype none

`include "vjc_params.svh"

package mem_req_pkg;

	// byte address into either array
	typedef logic [`VJC_ADDR_BITS-1:0] addr_t;

	// one memory line, word 0 in the low bits
	typedef logic [`VJC_LINE_WORDS*`VJC_WORD_BITS-1:0] line_t;

	// 0 selects out-degree, 1 selects edge index
	typedef logic array_sel_t;

	// valid words in a chunk, 0 up to a full line
	typedef logic [$clog2(`VJC_LINE_WORDS+1)-1:0] word_count_t;

endpackage

`default_nettype wire

/* source/vertex_job_pkg.sv */
////////////////////////////////////////////////////////////
// vertex job types
// job fields, vertex counts and the read sequencer states
////////////////////////////////////////////////////////////

`default_nettype none

`include "vjc_params.svh"

package vertex_job_pkg;

	// one array element
	typedef logic [`VJC_WORD_BITS-1:0] vertex_word_t;

	// vertex id handed to the consumer
	typedef logic [31:0] vertex_id_t;

	// vertex count of a run
	typedef logic [31:0] vertex_count_t;

	// read sequencer states
	typedef enum logic [2:0] {
		IDLE,
		ISSUE_DEGREE,
		ISSUE_EDGES,
		WAIT_DATA,
		UNPACK,
		NEXT_CHUNK
	} seq_state_t;

endpackage

`default_nettype wire

/* source/job_push_if.sv */
////////////////////////////////////////////////////////////
// job push interface
// carries assembled jobs into the queue and the queue's
// room flag back to the sequencer
////////////////////////////////////////////////////////////

`default_nettype none

interface job_push_if;

	logic                         push;
	vertex_job_pkg::vertex_id_t   id;
	vertex_job_pkg::vertex_word_t out_degree;
	vertex_job_pkg::vertex_word_t edges_idx;
	// at least one line of free entries
	logic                         room;

	modport assembler (
		output push,
		output id,
		output out_degree,
		output edges_idx
	);

	modport queue (
		input  push,
		input  id,
		input  out_degree,
		input  edges_idx,
		output room
	);

	modport sequencer (
		input room
	);

endinterface

`default_nettype wire

/* source/vertex_read_sequencer.sv */
////////////////////////////////////////////////////////////
// vertex read sequencer
// walks the vertex range one line at a time, issues the two
// array reads per chunk and paces the unpacking
////////////////////////////////////////////////////////////

`default_nettype none

`include "vjc_params.svh"

module vertex_read_sequencer (
	input  logic                          clock,
	input  logic                          rstn,
	input  logic                          start,
	input  vertex_job_pkg::vertex_count_t num_vertices,
	input  mem_req_pkg::addr_t            degree_base,
	input  mem_req_pkg::addr_t            edges_base,
	input  logic                          cmd_ready,
	input  logic                          degree_ready,
	input  logic                          edges_ready,
	job_push_if.sequencer                 jobs,
	output logic                          busy,
	output logic                          done,
	output logic                          cmd_valid,
	output mem_req_pkg::addr_t            cmd_address,
	output mem_req_pkg::array_sel_t       cmd_array,
	output mem_req_pkg::word_count_t      cmd_count,
	output logic                          shift,
	output logic                          line_release
);

	localparam mem_req_pkg::addr_t LINE_BYTES =
		mem_req_pkg::addr_t'(`VJC_LINE_WORDS * `VJC_WORD_BITS / 8);
	localparam vertex_job_pkg::vertex_count_t LINE_VERTICES =
		vertex_job_pkg::vertex_count_t'(`VJC_LINE_WORDS);

	vertex_job_pkg::seq_state_t    state;
	vertex_job_pkg::seq_state_t    next_state;
	mem_req_pkg::addr_t            degree_base_q;
	mem_req_pkg::addr_t            edges_base_q;
	mem_req_pkg::addr_t            chunk_offset;
	vertex_job_pkg::vertex_count_t remaining;
	mem_req_pkg::word_count_t      shift_count;
	logic                          last_shift;
	logic                          last_chunk;

	////////////////////////////////////////////////////////////
	// command fields
	////////////////////////////////////////////////////////////

	// short final chunk
	assign cmd_count = (remaining > LINE_VERTICES) ?
		mem_req_pkg::word_count_t'(`VJC_LINE_WORDS) :
		mem_req_pkg::word_count_t'(remaining);

	assign cmd_valid = (state == vertex_job_pkg::ISSUE_DEGREE) ||
		(state == vertex_job_pkg::ISSUE_EDGES);
	assign cmd_array = (state == vertex_job_pkg::ISSUE_EDGES) ? 1'b1 : 1'b0;
	assign cmd_address = ((state == vertex_job_pkg::ISSUE_EDGES) ?
		edges_base_q : degree_base_q) + chunk_offset;

	// one word per cycle while unpacking
	assign shift      = (state == vertex_job_pkg::UNPACK);
	assign last_shift = shift && (shift_count == cmd_count - 1'b1);
	assign last_chunk = (remaining <= LINE_VERTICES);

	////////////////////////////////////////////////////////////
	// state machine
	////////////////////////////////////////////////////////////

	always_comb begin
		next_state = state;
		case (state)
			vertex_job_pkg::IDLE: begin
				if (start)
					next_state = vertex_job_pkg::NEXT_CHUNK;
			end
			vertex_job_pkg::NEXT_CHUNK: begin
				// a new chunk only when a full line fits in the queue
				if (remaining == '0)
					next_state = vertex_job_pkg::IDLE;
				else if (jobs.room)
					next_state = vertex_job_pkg::ISSUE_DEGREE;
			end
			vertex_job_pkg::ISSUE_DEGREE: begin
				if (cmd_ready)
					next_state = vertex_job_pkg::ISSUE_EDGES;
			end
			vertex_job_pkg::ISSUE_EDGES: begin
				if (cmd_ready)
					next_state = vertex_job_pkg::WAIT_DATA;
			end
			vertex_job_pkg::WAIT_DATA: begin
				if (degree_ready && edges_ready)
					next_state = vertex_job_pkg::UNPACK;
			end
			vertex_job_pkg::UNPACK: begin
				if (last_shift)
					next_state = last_chunk ? vertex_job_pkg::IDLE :
						vertex_job_pkg::NEXT_CHUNK;
			end
			default: begin
				next_state = vertex_job_pkg::IDLE;
			end
		endcase
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state        <= vertex_job_pkg::IDLE;
			busy         <= 1'b0;
			done         <= 1'b0;
			line_release <= 1'b0;
			remaining    <= '0;
			chunk_offset <= '0;
			shift_count  <= '0;
		end else begin
			state        <= next_state;
			done         <= 1'b0;
			line_release <= 1'b0;
			if ((state == vertex_job_pkg::IDLE) && start) begin
				busy         <= 1'b1;
				remaining    <= num_vertices;
				chunk_offset <= '0;
			end
			// empty run ends right away
			if ((state == vertex_job_pkg::NEXT_CHUNK) && (remaining == '0)) begin
				busy <= 1'b0;
				done <= 1'b1;
			end
			if (shift)
				shift_count <= shift_count + 1'b1;
			if (last_shift) begin
				shift_count  <= '0;
				line_release <= 1'b1;
				remaining    <= remaining - vertex_job_pkg::vertex_count_t'(cmd_count);
				chunk_offset <= chunk_offset + LINE_BYTES;
				if (last_chunk) begin
					busy <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	// array bases held for the whole run
	always_ff @(posedge clock) begin
		if ((state == vertex_job_pkg::IDLE) && start) begin
			degree_base_q <= degree_base;
			edges_base_q  <= edges_base;
		end
	end

endmodule

`default_nettype wire

/* source/vertex_line_buffer.sv */
////////////////////////////////////////////////////////////
// vertex line buffer
// captures the returned line of one array and shifts its
// words out, word 0 first
////////////////////////////////////////////////////////////

`default_nettype none

`include "vjc_params.svh"

module vertex_line_buffer #(
	parameter mem_req_pkg::array_sel_t ARRAY_SEL = 1'b0
) (
	input  logic                         clock,
	input  logic                         rstn,
	input  logic                         data_valid,
	input  mem_req_pkg::array_sel_t      data_array,
	input  mem_req_pkg::line_t           data_line,
	input  logic                         shift,
	input  logic                         line_release,
	output logic                         line_ready,
	output vertex_job_pkg::vertex_word_t head_word
);

	localparam int LINE_BITS = `VJC_LINE_WORDS * `VJC_WORD_BITS;

	mem_req_pkg::line_t line_q;
	logic               capture;

	// only answers for this array are taken
	assign capture = data_valid && (data_array == ARRAY_SEL);

	always_ff @(posedge clock) begin
		if (capture)
			line_q <= data_line;
		else if (shift)
			line_q <= {{`VJC_WORD_BITS{1'b0}}, line_q[LINE_BITS-1:`VJC_WORD_BITS]};
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			line_ready <= 1'b0;
		end else begin
			if (line_release)
				line_ready <= 1'b0;
			if (capture)
				line_ready <= 1'b1;
		end
	end

	// lowest word is next out
	assign head_word = line_q[`VJC_WORD_BITS-1:0];

endmodule

`default_nettype wire

/* source/vertex_job_assembler.sv */
////////////////////////////////////////////////////////////
// vertex job assembler
// pairs the two head words with a running vertex id and
// pushes one job per shift
////////////////////////////////////////////////////////////

`default_nettype none

module vertex_job_assembler (
	input  logic                         clock,
	input  logic                         rstn,
	input  logic                         start,
	input  vertex_job_pkg::vertex_id_t   id_base,
	input  logic                         shift,
	input  vertex_job_pkg::vertex_word_t degree_word,
	input  vertex_job_pkg::vertex_word_t edges_word,
	job_push_if.assembler                jobs
);

	vertex_job_pkg::vertex_id_t id_counter;

	////////////////////////////////////////////////////////////
	// id counter and push strobe
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			id_counter <= '0;
			jobs.push  <= 1'b0;
		end else begin
			jobs.push <= shift;
			// run starts counting from the base offset
			if (start)
				id_counter <= id_base;
			else if (shift)
				id_counter <= id_counter + 1'b1;
		end
	end

	// job payload
	always_ff @(posedge clock) begin
		if (shift) begin
			jobs.id         <= id_counter;
			jobs.out_degree <= degree_word;
			jobs.edges_idx  <= edges_word;
		end
	end

endmodule

`default_nettype wire

/* source/vertex_job_fifo.sv */
////////////////////////////////////////////////////////////
// vertex job FIFO
// circular job queue with show-ahead output and a room flag
////////////////////////////////////////////////////////////

`default_nettype none

`include "vjc_params.svh"

module vertex_job_fifo (
	input  logic                         clock,
	input  logic                         rstn,
	job_push_if.queue                    jobs,
	input  logic                         job_pop,
	output logic                         job_valid,
	output vertex_job_pkg::vertex_id_t   job_id,
	output vertex_job_pkg::vertex_word_t job_out_degree,
	output vertex_job_pkg::vertex_word_t job_edges_idx
);

	localparam int PTR_BITS   = $clog2(`VJC_JOB_DEPTH);
	localparam int COUNT_BITS = $clog2(`VJC_JOB_DEPTH + 1);

	vertex_job_pkg::vertex_id_t   id_mem [`VJC_JOB_DEPTH];
	vertex_job_pkg::vertex_word_t degree_mem [`VJC_JOB_DEPTH];
	vertex_job_pkg::vertex_word_t edges_mem [`VJC_JOB_DEPTH];
	logic [PTR_BITS-1:0]          wr_ptr;
	logic [PTR_BITS-1:0]          rd_ptr;
	logic [COUNT_BITS-1:0]        count;
	logic [COUNT_BITS-1:0]        free_entries;
	logic                         pop_ok;

	assign pop_ok = job_pop && job_valid;

	// the push in flight already holds an entry
	assign free_entries = COUNT_BITS'(`VJC_JOB_DEPTH) - count - COUNT_BITS'(jobs.push);
	assign jobs.room    = (free_entries >= COUNT_BITS'(`VJC_LINE_WORDS));

	always_ff @(posedge clock) begin
		if (jobs.push) begin
			id_mem[wr_ptr]     <= jobs.id;
			degree_mem[wr_ptr] <= jobs.out_degree;
			edges_mem[wr_ptr]  <= jobs.edges_idx;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (jobs.push)
				wr_ptr <= (wr_ptr == PTR_BITS'(`VJC_JOB_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop_ok)
				rd_ptr <= (rd_ptr == PTR_BITS'(`VJC_JOB_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (jobs.push && !pop_ok)
				count <= count + 1'b1;
			else if (pop_ok && !jobs.push)
				count <= count - 1'b1;
		end
	end

	// oldest job is shown
	assign job_valid      = (count != '0);
	assign job_id         = id_mem[rd_ptr];
	assign job_out_degree = degree_mem[rd_ptr];
	assign job_edges_idx  = edges_mem[rd_ptr];

endmodule

`default_nettype wire

/* source/vertex_job_control.sv */
////////////////////////////////////////////////////////////
// vertex job controller
// reads out-degree and edge-index lines per chunk and turns
// them into queued vertex jobs
////////////////////////////////////////////////////////////

`default_nettype none

module vertex_job_control (
	input  logic                          clock,
	input  logic                          rstn,
	// run control
	input  logic                          start,
	input  vertex_job_pkg::vertex_count_t num_vertices,
	input  mem_req_pkg::addr_t            degree_base,
	input  mem_req_pkg::addr_t            edges_base,
	input  vertex_job_pkg::vertex_id_t    id_base,
	output logic                          busy,
	output logic                          done,
	// read commands
	output logic                          cmd_valid,
	output mem_req_pkg::addr_t            cmd_address,
	output mem_req_pkg::array_sel_t       cmd_array,
	output mem_req_pkg::word_count_t      cmd_count,
	input  logic                          cmd_ready,
	// read data
	input  logic                          data_valid,
	input  mem_req_pkg::array_sel_t       data_array,
	input  mem_req_pkg::line_t            data_line,
	// job queue
	output logic                          job_valid,
	output vertex_job_pkg::vertex_id_t    job_id,
	output vertex_job_pkg::vertex_word_t  job_out_degree,
	output vertex_job_pkg::vertex_word_t  job_edges_idx,
	input  logic                          job_pop
);

	logic                         degree_ready;
	logic                         edges_ready;
	vertex_job_pkg::vertex_word_t degree_word;
	vertex_job_pkg::vertex_word_t edges_word;
	logic                         shift;
	logic                         line_release;

	job_push_if jobs_if ();

	vertex_read_sequencer u_sequencer (
		.clock        (clock),
		.rstn         (rstn),
		.start        (start),
		.num_vertices (num_vertices),
		.degree_base  (degree_base),
		.edges_base   (edges_base),
		.cmd_ready    (cmd_ready),
		.degree_ready (degree_ready),
		.edges_ready  (edges_ready),
		.jobs         (jobs_if.sequencer),
		.busy         (busy),
		.done         (done),
		.cmd_valid    (cmd_valid),
		.cmd_address  (cmd_address),
		.cmd_array    (cmd_array),
		.cmd_count    (cmd_count),
		.shift        (shift),
		.line_release (line_release)
	);

	// out-degree line
	vertex_line_buffer #(.ARRAY_SEL(1'b0)) u_degree_buffer (
		.clock        (clock),
		.rstn         (rstn),
		.data_valid   (data_valid),
		.data_array   (data_array),
		.data_line    (data_line),
		.shift        (shift),
		.line_release (line_release),
		.line_ready   (degree_ready),
		.head_word    (degree_word)
	);

	// edge-index line
	vertex_line_buffer #(.ARRAY_SEL(1'b1)) u_edges_buffer (
		.clock        (clock),
		.rstn         (rstn),
		.data_valid   (data_valid),
		.data_array   (data_array),
		.data_line    (data_line),
		.shift        (shift),
		.line_release (line_release),
		.line_ready   (edges_ready),
		.head_word    (edges_word)
	);

	vertex_job_assembler u_assembler (
		.clock       (clock),
		.rstn        (rstn),
		.start       (start),
		.id_base     (id_base),
		.shift       (shift),
		.degree_word (degree_word),
		.edges_word  (edges_word),
		.jobs        (jobs_if.assembler)
	);

	vertex_job_fifo u_job_fifo (
		.clock          (clock),
		.rstn           (rstn),
		.jobs           (jobs_if.queue),
		.job_pop        (job_pop),
		.job_valid      (job_valid),
		.job_id         (job_id),
		.job_out_degree (job_out_degree),
		.job_edges_idx  (job_edges_idx)
	);

endmodule

`default_nettype wire

/* dv/tb_memory_model.sv */
////////////////////////////////////////////////////////////
// testbench memory model
// accepts line reads and answers each one after a random delay
////////////////////////////////////////////////////////////

`default_nettype none

`include "vjc_params.svh"

module tb_memory_model (
	input  logic                    clock,
	input  logic                    rstn,
	input  logic                    long_stalls,
	input  logic                    cmd_valid,
	input  mem_req_pkg::addr_t      cmd_address,
	input  mem_req_pkg::array_sel_t cmd_array,
	output logic                    cmd_ready,
	output logic                    data_valid,
	output mem_req_pkg::array_sel_t data_array,
	output mem_req_pkg::line_t      data_line
);

	timeunit 1ns;
	timeprecision 100ps;

	// accepted reads waiting for their answer
	mem_req_pkg::addr_t      pend_address [$];
	mem_req_pkg::array_sel_t pend_array [$];
	int                      pend_due [$];
	int                      cycle;

	// word at byte address A is A*3+1
	function automatic mem_req_pkg::line_t line_at(input mem_req_pkg::addr_t address);
		mem_req_pkg::line_t line;
		mem_req_pkg::addr_t word_address;
		line = '0;
		for (int k = 0; k < `VJC_LINE_WORDS; k++) begin
			word_address = address + mem_req_pkg::addr_t'(4 * k);
			line[k*`VJC_WORD_BITS +: `VJC_WORD_BITS] = word_address * 3 + 1;
		end
		return line;
	endfunction

	initial begin : serve_reads
		logic stalls_q;
		cmd_ready  = 1'b0;
		data_valid = 1'b0;
		data_array = 1'b0;
		data_line  = '0;
		cycle      = 0;
		forever begin
			@(posedge clock);
			cycle++;
			stalls_q = long_stalls;
			if (!rstn) begin
				pend_address.delete();
				pend_array.delete();
				pend_due.delete();
			end else if (cmd_valid && cmd_ready) begin
				pend_address.push_back(cmd_address);
				pend_array.push_back(cmd_array);
				pend_due.push_back(cycle + 2 + $urandom_range(7));
			end
			#1;
			// answers leave in order, one per cycle
			if ((pend_due.size() > 0) && (pend_due[0] <= cycle)) begin
				data_valid = 1'b1;
				data_array = pend_array.pop_front();
				data_line  = line_at(pend_address.pop_front());
				void'(pend_due.pop_front());
			end else begin
				data_valid = 1'b0;
			end
			if (stalls_q)
				cmd_ready = ((cycle % 25) == 0);
			else
				cmd_ready = ($urandom_range(3) != 0);
		end
	end

endmodule

`default_nettype wire

/* dv/tb_vertex_job_control.sv */
////////////////////////////////////////////////////////////
// vertex job controller testbench
// runs several vertex ranges and checks commands and jobs
// against a reference model
////////////////////////////////////////////////////////////

`default_nettype none

`include "vjc_params.svh"

module tb_vertex_job_control;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int TOTAL_VERTICES = 8 + 21 + 40 + 16 + 0 + 12;
	localparam int TIMEOUT_CYCLES = 400 + 40 * TOTAL_VERTICES;
	localparam int LINE_BYTES     = `VJC_LINE_WORDS * `VJC_WORD_BITS / 8;

	typedef struct packed {
		logic [31:0] id;
		logic [31:0] out_degree;
		logic [31:0] edges_idx;
	} job_t;

	logic                          clock;
	logic                          rstn;
	logic                          start;
	vertex_job_pkg::vertex_count_t num_vertices;
	mem_req_pkg::addr_t            degree_base;
	mem_req_pkg::addr_t            edges_base;
	vertex_job_pkg::vertex_id_t    id_base;
	logic                          busy;
	logic                          done;
	logic                          cmd_valid;
	mem_req_pkg::addr_t            cmd_address;
	mem_req_pkg::array_sel_t       cmd_array;
	mem_req_pkg::word_count_t      cmd_count;
	logic                          cmd_ready;
	logic                          data_valid;
	mem_req_pkg::array_sel_t       data_array;
	mem_req_pkg::line_t            data_line;
	logic                          job_valid;
	vertex_job_pkg::vertex_id_t    job_id;
	vertex_job_pkg::vertex_word_t  job_out_degree;
	vertex_job_pkg::vertex_word_t  job_edges_idx;
	logic                          job_pop;
	logic                          long_stalls;

	// current run and bookkeeping
	int          errors;
	int          jobs_checked;
	int          jobs_seen;
	int          cmd_seen;
	int          done_count;
	int          run_n;
	logic [31:0] run_dbase;
	logic [31:0] run_ebase;
	logic [31:0] run_ibase;
	logic        pop_hold;
	logic        held_valid;
	logic        prev_valid;
	logic        prev_ready;
	logic        prev_busy;
	logic [31:0] prev_address;
	logic [31:0] prev_array;
	logic [31:0] prev_count;

	vertex_job_control uut (
		.clock          (clock),
		.rstn           (rstn),
		.start          (start),
		.num_vertices   (num_vertices),
		.degree_base    (degree_base),
		.edges_base     (edges_base),
		.id_base        (id_base),
		.busy           (busy),
		.done           (done),
		.cmd_valid      (cmd_valid),
		.cmd_address    (cmd_address),
		.cmd_array      (cmd_array),
		.cmd_count      (cmd_count),
		.cmd_ready      (cmd_ready),
		.data_valid     (data_valid),
		.data_array     (data_array),
		.data_line      (data_line),
		.job_valid      (job_valid),
		.job_id         (job_id),
		.job_out_degree (job_out_degree),
		.job_edges_idx  (job_edges_idx),
		.job_pop        (job_pop)
	);

	tb_memory_model memory (
		.clock       (clock),
		.rstn        (rstn),
		.long_stalls (long_stalls),
		.cmd_valid   (cmd_valid),
		.cmd_address (cmd_address),
		.cmd_array   (cmd_array),
		.cmd_ready   (cmd_ready),
		.data_valid  (data_valid),
		.data_array  (data_array),
		.data_line   (data_line)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	////////////////////////////////////////////////////////////
	// reference model and checks
	////////////////////////////////////////////////////////////

	// job i reads element i of both arrays
	function automatic job_t reference_job(input int index, input logic [31:0] dbase,
		input logic [31:0] ebase, input logic [31:0] ibase);
		job_t        job;
		logic [31:0] degree_address;
		logic [31:0] edges_address;
		degree_address = dbase + 32'(4 * index);
		edges_address  = ebase + 32'(4 * index);
		job.id         = ibase + 32'(index);
		job.out_degree = degree_address * 3 + 1;
		job.edges_idx  = edges_address * 3 + 1;
		return job;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("MISMATCH %0t %s expected %h actual %h", $time, name, expected, actual);
			errors++;
		end
	endtask

	task automatic report_failure(input string what);
		$display("ERROR %0t %s", $time, what);
		errors++;
	endtask

	// pops jobs and compares them in order
	initial begin : compare_jobs
		job_t expected;
		logic hold_q;
		job_pop    = 1'b0;
		held_valid = 1'b0;
		forever begin
			@(posedge clock);
			hold_q = pop_hold;
			if (rstn && job_valid && job_pop) begin
				if (jobs_seen >= run_n) begin
					report_failure("job popped beyond the end of the run");
				end else begin
					expected = reference_job(jobs_seen, run_dbase, run_ebase, run_ibase);
					check_value("job_id", expected.id, job_id);
					check_value("job_out_degree", expected.out_degree, job_out_degree);
					check_value("job_edges_idx", expected.edges_idx, job_edges_idx);
					jobs_checked++;
				end
				jobs_seen++;
			end
			if (hold_q && held_valid && !job_valid)
				report_failure("job_valid fell while popping was held off");
			held_valid = hold_q && (held_valid || job_valid);
			#1;
			job_pop = !hold_q && ($urandom_range(3) != 0);
		end
	end

	// read commands, stability and done timing
	initial begin : watch_commands
		int          chunk;
		int          exp_count;
		logic [31:0] exp_address;
		forever begin
			@(posedge clock);
			if (rstn) begin
				if (cmd_valid && (run_n == 0))
					report_failure("read command issued for an empty run");
				if (prev_valid && !prev_ready) begin
					if (!cmd_valid) begin
						report_failure("cmd_valid dropped before cmd_ready");
					end else begin
						check_value("cmd_address", prev_address, cmd_address);
						check_value("cmd_array", prev_array, 32'(cmd_array));
						check_value("cmd_count", prev_count, 32'(cmd_count));
					end
				end
				if (cmd_valid && cmd_ready) begin
					chunk = cmd_seen / 2;
					if (cmd_seen >= 2 * ((run_n + `VJC_LINE_WORDS - 1) / `VJC_LINE_WORDS)) begin
						report_failure("extra read command in the run");
					end else begin
						exp_count   = run_n - `VJC_LINE_WORDS * chunk;
						if (exp_count > `VJC_LINE_WORDS)
							exp_count = `VJC_LINE_WORDS;
						exp_address = ((cmd_seen % 2) ? run_ebase : run_dbase) +
							32'(LINE_BYTES * chunk);
						check_value("cmd_array", 32'(cmd_seen % 2), 32'(cmd_array));
						check_value("cmd_address", exp_address, cmd_address);
						check_value("cmd_count", 32'(exp_count), 32'(cmd_count));
					end
					cmd_seen++;
				end
				if (done) begin
					done_count++;
					if (busy)
						report_failure("busy still high when done pulsed");
					if (!prev_busy)
						report_failure("done pulsed without a busy run before it");
				end
			end
			prev_valid   = cmd_valid;
			prev_ready   = cmd_ready;
			prev_busy    = busy;
			prev_address = cmd_address;
			prev_array   = 32'(cmd_array);
			prev_count   = 32'(cmd_count);
		end
	end

	////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////

	// one run from start to the last job, entered 1 ns after an edge
	task automatic run_vertices(input int n, input logic [31:0] dbase,
		input logic [31:0] ebase, input logic [31:0] ibase, input int hold_cycles,
		input logic stalls);
		run_n        = n;
		run_dbase    = dbase;
		run_ebase    = ebase;
		run_ibase    = ibase;
		jobs_seen    = 0;
		cmd_seen     = 0;
		done_count   = 0;
		long_stalls  = stalls;
		start        = 1'b1;
		num_vertices = n;
		degree_base  = dbase;
		edges_base   = ebase;
		id_base      = ibase;
		@(posedge clock);
		#1;
		start = 1'b0;
		if (hold_cycles > 0) begin
			pop_hold = 1'b1;
			repeat (hold_cycles) @(posedge clock);
			#1;
			pop_hold = 1'b0;
		end
		while ((done_count == 0) || (jobs_seen < n)) begin
			@(posedge clock);
			#1;
		end
		long_stalls = 1'b0;
		repeat (5) @(posedge clock);
		#1;
		if (job_valid)
			report_failure("extra job left in the queue after the run");
		if (done_count != 1)
			report_failure("done did not pulse exactly once");
		if (cmd_seen != 2 * ((n + `VJC_LINE_WORDS - 1) / `VJC_LINE_WORDS))
			report_failure("wrong number of read commands in the run");
	endtask

	initial begin : main
		void'($urandom(32'h44e2fd48));
		errors       = 0;
		jobs_checked = 0;
		jobs_seen    = 0;
		cmd_seen     = 0;
		done_count   = 0;
		run_n        = 0;
		run_dbase    = '0;
		run_ebase    = '0;
		run_ibase    = '0;
		pop_hold     = 1'b0;
		long_stalls  = 1'b0;
		rstn         = 1'b0;
		start        = 1'b0;
		num_vertices = '0;
		degree_base  = '0;
		edges_base   = '0;
		id_base      = '0;
		repeat (3) @(posedge clock);
		#1;
		rstn = 1'b1;
		repeat (2) @(posedge clock);
		#1;
		// single line, then a short final chunk
		run_vertices(8, 32'h0000_1000, 32'h0000_8000, 32'd0, 0, 1'b0);
		run_vertices(21, 32'h2000_0040, 32'h3000_0100, 32'd100, 0, 1'b0);
		// consumer held off, queue fills
		run_vertices(40, 32'h0000_4000, 32'h0000_9000, 32'd1000, 200, 1'b0);
		// memory holds cmd_ready low for long stretches
		run_vertices(16, 32'h0000_5000, 32'h0000_a000, 32'd77, 0, 1'b1);
		// empty run, then a new id base
		run_vertices(0, 32'h0000_7000, 32'h0000_c000, 32'd500, 0, 1'b0);
		run_vertices(12, 32'h0000_6000, 32'h0000_b000, 32'd5000, 0, 1'b0);
		$display("%0d errors, %0d jobs checked", errors, jobs_checked);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

	// limit on the whole run
	initial begin : watchdog
		int cycles;
		for (cycles = 0; cycles < TIMEOUT_CYCLES; cycles++)
			@(posedge clock);
		$display("timeout: the run stalled after %0d cycles", cycles);
		$display("%0d errors, %0d jobs checked", errors, jobs_checked);
		$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
+incdir+source
source/mem_req_pkg.sv
source/vertex_job_pkg.sv
source/job_push_if.sv
source/vertex_read_sequencer.sv
source/vertex_line_buffer.sv
source/vertex_job_assembler.sv
source/vertex_job_fifo.sv
source/vertex_job_control.sv
dv/tb_memory_model.sv
dv/tb_vertex_job_control.sv
